//--- Bender.yml
package:
  name: pc_unit

sources:
  - hw/pc_unit_pkg.sv
  - hw/serial_adder.sv
  - hw/pc_shift_reg.sv
  - hw/operand_serializer.sv
  - hw/pc_ctrl.sv
  - hw/result_deserializer.sv
  - hw/pc_unit_top.sv
  - target: test
    files:
      - dv/pc_unit_tb.sv

//--- dv/pc_unit_tb.sv
`timescale 1ns/10ps

module pc_unit_tb;

   logic               clk;
   logic               i_rst_n;
   logic               i_start;
   pc_unit_pkg::op_e   i_op;
   pc_unit_pkg::word_t i_offset;
   pc_unit_pkg::word_t i_rs1;
   pc_unit_pkg::word_t i_trap_pc;
   logic               i_ibus_ack;
   logic               o_busy;
   logic               o_result_valid;
   pc_unit_pkg::word_t o_rd_data;
   pc_unit_pkg::word_t o_target;
   logic               o_misalign;
   pc_unit_pkg::word_t o_ibus_adr;
   logic               o_ibus_cyc;

   integer seed;
   integer ack_wait;
   logic   hold_ack;
   logic   aborted;
   int     cyc_cnt = 0;
   int     err_cnt = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     expected_results = 0;
   int     results_seen = 0;

   pc_unit_pkg::word_t model_pc;

   // Expected values, one entry per accepted operation.
   string              name_q[$];
   pc_unit_pkg::word_t rd_q[$];
   pc_unit_pkg::word_t tgt_q[$];
   pc_unit_pkg::word_t adr_q[$];
   logic               mis_q[$];
   int                 start_q[$];

   pc_unit_top dut_i (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_start        (i_start),
      .i_op           (i_op),
      .i_offset       (i_offset),
      .i_rs1          (i_rs1),
      .i_trap_pc      (i_trap_pc),
      .i_ibus_ack     (i_ibus_ack),
      .o_busy         (o_busy),
      .o_result_valid (o_result_valid),
      .o_rd_data      (o_rd_data),
      .o_target       (o_target),
      .o_misalign     (o_misalign),
      .o_ibus_adr     (o_ibus_adr),
      .o_ibus_cyc     (o_ibus_cyc)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cyc_cnt <= cyc_cnt + 1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model and compare tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic void ref_step(
      input  pc_unit_pkg::op_e   op,
      input  pc_unit_pkg::word_t offset,
      input  pc_unit_pkg::word_t rs1,
      input  pc_unit_pkg::word_t trap_pc,
      output pc_unit_pkg::word_t rd,
      output pc_unit_pkg::word_t tgt,
      output pc_unit_pkg::word_t next_pc,
      output logic               mis
   );
      pc_unit_pkg::word_t base;
      base = (op == pc_unit_pkg::op_jalr) ? rs1 : model_pc;
      tgt  = (base + offset) & ~32'd1;
      mis  = tgt[1];
      rd   = (op == pc_unit_pkg::op_auipc) ? tgt : model_pc + 32'd4;
      case (op)
         pc_unit_pkg::op_trap:  next_pc = trap_pc & ~32'd1;
         pc_unit_pkg::op_jal:   next_pc = tgt;
         pc_unit_pkg::op_jalr:  next_pc = tgt;
         default:               next_pc = model_pc + 32'd4;
      endcase
      model_pc = next_pc;
   endfunction

   task automatic check_word(input string name, input pc_unit_pkg::word_t exp,
                             input pc_unit_pkg::word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
         err_cnt++;
      end
   endtask

   // Every result strobe is matched against the oldest outstanding operation.
   always @(negedge clk) begin : compare_results
      string name;
      if (i_rst_n && o_result_valid) begin
         if (name_q.size() == 0) begin
            $display("Result strobe seen with no operation outstanding");
            err_cnt++;
         end else begin
            name = name_q.pop_front();
            check_word({name, " rd"}, rd_q.pop_front(), o_rd_data);
            check_word({name, " target"}, tgt_q.pop_front(), o_target);
            check_bit({name, " misalign"}, mis_q.pop_front(), o_misalign);
            check_bit({name, " ibus cyc"}, 1'b1, o_ibus_cyc);
            check_word({name, " fetch adr"}, adr_q.pop_front(), o_ibus_adr);
            check_count({name, " latency"}, 33, cyc_cnt - start_q.pop_front());
         end
         results_seen <= results_seen + 1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Instruction bus responder
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always @(negedge clk) begin
      if (!i_rst_n) begin
         i_ibus_ack = 1'b0;
         ack_wait   = -1;
      end else if (i_ibus_ack) begin
         i_ibus_ack = 1'b0;
      end else if (o_ibus_cyc && !hold_ack) begin
         if (ack_wait < 0) begin
            ack_wait = $unsigned($random(seed)) % 6;
         end
         if (ack_wait == 0) begin
            i_ibus_ack = 1'b1;
            ack_wait   = -1;
         end else begin
            ack_wait = ack_wait - 1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic wait_idle();
      int n;
      n = 0;
      while (o_busy && n < 100) begin
         @(negedge clk);
         n++;
      end
      if (o_busy) begin
         $display("Timeout: o_busy stayed high for 100 cycles");
         aborted = 1'b1;
      end
   endtask

   task automatic wait_result();
      int n;
      n = 0;
      while (results_seen != expected_results && n < 100) begin
         @(negedge clk);
         n++;
      end
      if (results_seen != expected_results) begin
         $display("Timeout: no o_result_valid pulse within 100 cycles");
         aborted = 1'b1;
      end
   endtask

   task automatic start_op(input string name, input pc_unit_pkg::op_e op,
                           input pc_unit_pkg::word_t offset, input pc_unit_pkg::word_t rs1,
                           input pc_unit_pkg::word_t trap_pc);
      pc_unit_pkg::word_t rd;
      pc_unit_pkg::word_t tgt;
      pc_unit_pkg::word_t next_pc;
      logic               mis;
      wait_idle();
      if (aborted) return;
      i_start   = 1'b1;
      i_op      = op;
      i_offset  = offset;
      i_rs1     = rs1;
      i_trap_pc = trap_pc;
      ref_step(op, offset, rs1, trap_pc, rd, tgt, next_pc, mis);
      name_q.push_back(name);
      rd_q.push_back(rd);
      tgt_q.push_back(tgt);
      adr_q.push_back(next_pc);
      mis_q.push_back(mis);
      start_q.push_back(cyc_cnt + 1);
      expected_results++;
      @(negedge clk);
      i_start = 1'b0;
   endtask

   task automatic run_op(input string name, input pc_unit_pkg::op_e op,
                         input pc_unit_pkg::word_t offset, input pc_unit_pkg::word_t rs1,
                         input pc_unit_pkg::word_t trap_pc);
      if (aborted) return;
      start_op(name, op, offset, rs1, trap_pc);
      if (aborted) return;
      wait_result();
      if (aborted) return;
      wait_idle();
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (err_cnt == errs_before) begin
         $display("[ok]   %s", name);
      end else begin
         $display("[FAIL] %s, %0d errors", name, err_cnt - errs_before);
         tests_failed++;
      end
   endtask

   task automatic test_reset_and_first_step();
      int base;
      base = err_cnt;
      check_bit("after reset busy", 1'b0, o_busy);
      check_bit("after reset ibus cyc", 1'b0, o_ibus_cyc);
      check_bit("after reset misalign", 1'b0, o_misalign);
      run_op("first step", pc_unit_pkg::op_step, 32'h0000_0100, '0, '0);
      if (aborted) return;
      check_word("first step rd", 32'd12, o_rd_data);
      check_word("first step fetch", 32'd12, o_ibus_adr);
      report_test("reset_and_first_step", base);
   endtask

   task automatic test_step_jal_auipc_chain();
      int               base;
      int               sel;
      pc_unit_pkg::op_e op;
      base = err_cnt;
      for (int i = 0; i < 12; i++) begin
         sel = $unsigned($random(seed)) % 3;
         case (sel)
            0:       op = pc_unit_pkg::op_step;
            1:       op = pc_unit_pkg::op_jal;
            default: op = pc_unit_pkg::op_auipc;
         endcase
         run_op($sformatf("chain %0d %s", i, op.name()), op, $random(seed), $random(seed), '0);
         if (aborted) return;
      end
      report_test("step_jal_auipc_chain", base);
   endtask

   task automatic test_jalr_alignment();
      int base;
      base = err_cnt;
      for (int i = 0; i < 8; i++) begin
         run_op($sformatf("jalr %0d", i), pc_unit_pkg::op_jalr,
                $random(seed) | 32'd1, $random(seed), '0);
         if (aborted) return;
         check_bit($sformatf("jalr %0d target bit 0", i), 1'b0, o_target[0]);
      end
      report_test("jalr_alignment", base);
   endtask

   task automatic test_trap_redirect();
      int base;
      base = err_cnt;
      run_op("trap", pc_unit_pkg::op_trap, $random(seed), '0, $random(seed) | 32'd1);
      run_op("step after trap", pc_unit_pkg::op_step, $random(seed), '0, '0);
      if (aborted) return;
      report_test("trap_redirect", base);
   endtask

   task automatic test_ack_backpressure();
      int base;
      base     = err_cnt;
      hold_ack = 1'b1;
      start_op("held jal", pc_unit_pkg::op_jal, 32'h0000_0040, '0, '0);
      if (aborted) return;
      wait_result();
      if (aborted) return;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         check_bit("held cyc", 1'b1, o_ibus_cyc);
         check_bit("held busy", 1'b1, o_busy);
         check_word("held adr", model_pc, o_ibus_adr);
         // This start lands while busy and must not touch the PC.
         if (i == 3) begin
            i_start  = 1'b1;
            i_op     = pc_unit_pkg::op_jal;
            i_offset = 32'h0000_1000;
         end else begin
            i_start = 1'b0;
         end
      end
      hold_ack = 1'b0;
      wait_idle();
      run_op("step after ignored start", pc_unit_pkg::op_step, '0, '0, '0);
      if (aborted) return;
      report_test("ack_backpressure", base);
   endtask

   initial begin
      seed      = 32'hb83f_c469;
      clk       = 1'b0;
      i_rst_n   = 1'b0;
      i_start   = 1'b0;
      i_op      = pc_unit_pkg::op_step;
      i_offset  = '0;
      i_rs1     = '0;
      i_trap_pc = '0;
      i_ibus_ack = 1'b0;
      hold_ack  = 1'b0;
      aborted   = 1'b0;
      ack_wait  = -1;
      model_pc  = pc_unit_pkg::reset_pc;
      repeat (4) @(negedge clk);
      i_rst_n = 1'b1;
      @(negedge clk);

      test_reset_and_first_step();
      test_step_jal_auipc_chain();
      test_jalr_alignment();
      test_trap_redirect();
      test_ack_backpressure();

      $display("Summary: %0d tests run, %0d failed, %0d check errors",
               tests_run, tests_failed, err_cnt);
      if (aborted || err_cnt != 0) begin
         $display("Test failures found");
      end else begin
         $display("All tests passed!");
      end
      $finish;
   end

endmodule

//--- hw/operand_serializer.sv
`timescale 1ns/10ps

module operand_serializer (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_start,
   input  pc_unit_pkg::op_e   i_op,
   input  pc_unit_pkg::word_t i_offset,
   input  pc_unit_pkg::word_t i_rs1,
   input  pc_unit_pkg::word_t i_trap_pc,
   input  logic               i_fetch_done,
   output logic               o_busy,
   output logic               o_en,
   output logic               o_last,
   output logic               o_offset,
   output logic               o_rs1,
   output logic               o_trap_pc,
   output logic               o_jump,
   output logic               o_jalr,
   output logic               o_auipc,
   output logic               o_trap
);

   logic                           start_ok;
   logic                           busy_q;
   logic                           en_q;
   logic [pc_unit_pkg::cnt_w-1:0]  cnt_q;
   pc_unit_pkg::op_e               op_q;

   pc_unit_pkg::word_t offset_sr;
   pc_unit_pkg::word_t rs1_sr;
   pc_unit_pkg::word_t trap_pc_sr;

   // A start while an operation is still in flight is dropped.
   assign start_ok = i_start & ~busy_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bit counter and busy tracking
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy_q <= 1'b0;
         en_q   <= 1'b0;
         cnt_q  <= '0;
         op_q   <= pc_unit_pkg::op_step;
      end else if (start_ok) begin
         busy_q <= 1'b1;
         en_q   <= 1'b1;
         cnt_q  <= '0;
         op_q   <= i_op;
      end else begin
         if (en_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (o_last) begin
               en_q <= 1'b0;
            end
         end
         // Busy covers the serial window and the whole bus cycle after it.
         if (i_fetch_done) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Operand shift registers, LSB out first.
   always_ff @(posedge clk) begin
      if (start_ok) begin
         offset_sr  <= i_offset;
         rs1_sr     <= i_rs1;
         trap_pc_sr <= i_trap_pc;
      end else if (en_q) begin
         offset_sr  <= {1'b0, offset_sr[pc_unit_pkg::xlen-1:1]};
         rs1_sr     <= {1'b0, rs1_sr[pc_unit_pkg::xlen-1:1]};
         trap_pc_sr <= {1'b0, trap_pc_sr[pc_unit_pkg::xlen-1:1]};
      end
   end

   assign o_busy    = busy_q;
   assign o_en      = en_q;
   assign o_last    = en_q & (&cnt_q);
   assign o_offset  = offset_sr[0];
   assign o_rs1     = rs1_sr[0];
   assign o_trap_pc = trap_pc_sr[0];

   // Decoded levels stay put from start until the next accepted start.
   assign o_jalr  = (op_q == pc_unit_pkg::op_jalr);
   assign o_jump  = (op_q == pc_unit_pkg::op_jal) | o_jalr;
   assign o_auipc = (op_q == pc_unit_pkg::op_auipc);
   assign o_trap  = (op_q == pc_unit_pkg::op_trap);

endmodule

//--- hw/pc_ctrl.sv
`timescale 1ns/10ps

module pc_ctrl (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_en,
   input  logic               i_last,
   input  logic               i_offset,
   input  logic               i_rs1,
   input  logic               i_trap_pc,
   input  logic               i_jump,
   input  logic               i_jalr,
   input  logic               i_auipc,
   input  logic               i_trap,
   input  logic               i_ibus_ack,
   output logic               o_rd,
   output logic               o_target,
   output logic               o_misalign,
   output pc_unit_pkg::word_t o_ibus_adr,
   output logic               o_ibus_cyc,
   output logic               o_fetch_done,
   output logic               o_result_valid
);

   logic en_r;
   logic en_2r;
   logic en_3r;

   logic first_bit;
   logic second_bit;
   logic third_bit;

   logic adder_clr;
   logic pc_bit;
   logic pc_plus_4;
   logic pc_plus_offset;
   logic offset_base;
   logic target_bit;
   logic new_pc;

   logic [pc_unit_pkg::xlen-1:1] pc_par;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bit position from the enable history
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign first_bit  = i_en & ~en_r;
   assign second_bit = en_r & ~en_2r;
   assign third_bit  = en_2r & ~en_3r;

   // Carries start at zero in the first bit cycle of every word.
   assign adder_clr = i_last | ~i_en;

   // Adding 4 means a single one in bit position 2.
   serial_adder pc_plus_4_i (
      .clk   (clk),
      .i_a   (pc_bit),
      .i_b   (third_bit),
      .i_clr (adder_clr),
      .o_q   (pc_plus_4)
   );

   assign offset_base = i_jalr ? i_rs1 : pc_bit;

   serial_adder pc_plus_offset_i (
      .clk   (clk),
      .i_a   (offset_base),
      .i_b   (i_offset),
      .i_clr (adder_clr),
      .o_q   (pc_plus_offset)
   );

   // Jump targets are always halfword aligned.
   assign target_bit = pc_plus_offset & ~first_bit;

   always_comb begin
      if (i_trap) begin
         new_pc = i_trap_pc & ~first_bit;
      end else if (i_jump) begin
         new_pc = target_bit;
      end else begin
         new_pc = pc_plus_4;
      end
   end

   pc_shift_reg pc_reg_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_en    (i_en),
      .i_d     (new_pc),
      .o_q     (pc_bit),
      .o_par   (pc_par)
   );

   assign o_rd       = i_auipc ? target_bit : pc_plus_4;
   assign o_target   = target_bit;
   assign o_ibus_adr = {pc_par, pc_bit};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Misalignment and instruction fetch
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         en_r           <= 1'b0;
         en_2r          <= 1'b0;
         en_3r          <= 1'b0;
         o_misalign     <= 1'b0;
         o_ibus_cyc     <= 1'b0;
         o_result_valid <= 1'b0;
      end else begin
         en_r  <= i_en;
         en_2r <= en_r;
         en_3r <= en_2r;

         // Bit 1 of the target passes the adder in the second bit cycle.
         if (second_bit) begin
            o_misalign <= pc_plus_offset;
         end

         // The PC register is complete once the enable has dropped.
         o_result_valid <= en_r & ~i_en;
         if (en_r & ~i_en) begin
            o_ibus_cyc <= 1'b1;
         end else if (o_fetch_done) begin
            o_ibus_cyc <= 1'b0;
         end
      end
   end

   assign o_fetch_done = o_ibus_cyc & i_ibus_ack;

endmodule

//--- hw/pc_shift_reg.sv
`timescale 1ns/10ps

module pc_shift_reg (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_en,
   input  logic                          i_d,
   output logic                          o_q,
   output logic [pc_unit_pkg::xlen-1:1]  o_par
);

   pc_unit_pkg::word_t pc_q;

   // Bit 0 leaves first and the new bit enters at the top, so after a full
   // word of shifts the register holds the new value in natural order.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q <= pc_unit_pkg::reset_pc;
      end else if (i_en) begin
         pc_q <= {i_d, pc_q[pc_unit_pkg::xlen-1:1]};
      end
   end

   assign o_q   = pc_q[0];
   assign o_par = pc_q[pc_unit_pkg::xlen-1:1];

endmodule

//--- hw/pc_unit_pkg.sv
package pc_unit_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Widths and reset values
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int unsigned xlen = 32;

   // The counter covers one bit position per cycle of a word.
   localparam int unsigned cnt_w = 5;

   // First fetch after reset goes to reset_pc + 4.
   localparam logic [xlen-1:0] reset_pc = 32'd8;

   typedef logic [xlen-1:0] word_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operation encoding
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // op_auipc writes PC+offset to the result but still steps the PC by 4.
   // op_trap takes the next PC from the trap operand.
   typedef enum logic [2:0] {
      op_step  = 3'd0,
      op_jal   = 3'd1,
      op_jalr  = 3'd2,
      op_auipc = 3'd3,
      op_trap  = 3'd4
   } op_e;

endpackage

//--- hw/pc_unit_top.sv
`timescale 1ns/10ps

module pc_unit_top (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_start,
   input  pc_unit_pkg::op_e   i_op,
   input  pc_unit_pkg::word_t i_offset,
   input  pc_unit_pkg::word_t i_rs1,
   input  pc_unit_pkg::word_t i_trap_pc,
   input  logic               i_ibus_ack,
   output logic               o_busy,
   output logic               o_result_valid,
   output pc_unit_pkg::word_t o_rd_data,
   output pc_unit_pkg::word_t o_target,
   output logic               o_misalign,
   output pc_unit_pkg::word_t o_ibus_adr,
   output logic               o_ibus_cyc
);

   logic ser_en;
   logic ser_last;
   logic ser_offset;
   logic ser_rs1;
   logic ser_trap_pc;
   logic ser_jump;
   logic ser_jalr;
   logic ser_auipc;
   logic ser_trap;
   logic fetch_done;
   logic rd_bit;
   logic tgt_bit;

   operand_serializer serializer_i (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_start      (i_start),
      .i_op         (i_op),
      .i_offset     (i_offset),
      .i_rs1        (i_rs1),
      .i_trap_pc    (i_trap_pc),
      .i_fetch_done (fetch_done),
      .o_busy       (o_busy),
      .o_en         (ser_en),
      .o_last       (ser_last),
      .o_offset     (ser_offset),
      .o_rs1        (ser_rs1),
      .o_trap_pc    (ser_trap_pc),
      .o_jump       (ser_jump),
      .o_jalr       (ser_jalr),
      .o_auipc      (ser_auipc),
      .o_trap       (ser_trap)
   );

   pc_ctrl ctrl_i (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_en           (ser_en),
      .i_last         (ser_last),
      .i_offset       (ser_offset),
      .i_rs1          (ser_rs1),
      .i_trap_pc      (ser_trap_pc),
      .i_jump         (ser_jump),
      .i_jalr         (ser_jalr),
      .i_auipc        (ser_auipc),
      .i_trap         (ser_trap),
      .i_ibus_ack     (i_ibus_ack),
      .o_rd           (rd_bit),
      .o_target       (tgt_bit),
      .o_misalign     (o_misalign),
      .o_ibus_adr     (o_ibus_adr),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_fetch_done   (fetch_done),
      .o_result_valid (o_result_valid)
   );

   // Result words are collected during the same enable window.
   result_deserializer rd_deser_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_en    (ser_en),
      .i_d     (rd_bit),
      .o_word  (o_rd_data)
   );

   result_deserializer tgt_deser_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_en    (ser_en),
      .i_d     (tgt_bit),
      .o_word  (o_target)
   );

endmodule

//--- hw/result_deserializer.sv
`timescale 1ns/10ps

module result_deserializer (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_en,
   input  logic               i_d,
   output pc_unit_pkg::word_t o_word
);

   pc_unit_pkg::word_t word_q;

   // Bits arrive LSB first and enter at the top, so after a full word
   // the first bit has moved down to position 0.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         word_q <= '0;
      end else if (i_en) begin
         word_q <= {i_d, word_q[pc_unit_pkg::xlen-1:1]};
      end
   end

   assign o_word = word_q;

endmodule

//--- hw/serial_adder.sv
`timescale 1ns/10ps

module serial_adder (
   input  logic clk,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry_q;
   logic carry_d;

   // Sum of the two operand bits and the carry from the previous bit.
   assign o_q     = i_a ^ i_b ^ carry_q;
   assign carry_d = (i_a & i_b) | (carry_q & (i_a ^ i_b));

   // The carry is dropped after the last bit so the next word starts clean.
   always_ff @(posedge clk) begin
      if (i_clr) begin
         carry_q <= 1'b0;
      end else begin
         carry_q <= carry_d;
      end
   end

endmodule

//--- pc_unit_top.f
hw/pc_unit_pkg.sv
hw/serial_adder.sv
hw/pc_shift_reg.sv
hw/operand_serializer.sv
hw/pc_ctrl.sv
hw/result_deserializer.sv
hw/pc_unit_top.sv
dv/pc_unit_tb.sv
